// ==== hdl/bp_pkg.sv ====
// Predictor types shared by the fetch-stage branch predictor blocks
// Counter encodings, the NPC to PC rule and the PHT reset rule live here
package bp_pkg;

	typedef logic [63:0] addr_t;                // Byte address for PCs and targets
	typedef logic [1:0]  pht_ctr_t;             // 2-bit saturating direction counter

	localparam pht_ctr_t PHT_STRONG_NT = 2'd0;
	localparam pht_ctr_t PHT_WEAK_NT   = 2'd1;
	localparam pht_ctr_t PHT_WEAK_T    = 2'd2;  // Upper bit set means taken
	localparam pht_ctr_t PHT_STRONG_T  = 2'd3;

	localparam addr_t INST_BYTES = 64'd4;       // Fetch slot is one 32-bit word

	// PC of the instruction whose next PC is given
	function automatic addr_t pc_of(addr_t npc);
		return npc - INST_BYTES;
	endfunction

	// Histories of all ones (1, 3, 7, ...) start weakly taken
	// so that loops warm up faster, everything else weakly not taken
	function automatic pht_ctr_t pht_reset_value(int unsigned idx);
		if (idx != 0 && ((idx & (idx + 1)) == 0)) begin
			return PHT_WEAK_T;
		end
		return PHT_WEAK_NT;
	endfunction

endpackage

// ==== hdl/alpha_isa_pkg.sv ====
// Alpha instruction fields needed to spot calls and returns at fetch
// Used by the call and return decode in front of the return address stack
package alpha_isa_pkg;

	typedef logic [31:0] inst_t;                // Raw instruction word
	typedef logic [5:0]  opcode_t;              // Bits 31 down to 26
	typedef logic [1:0]  jgrp_t;                // Jump hint group, bits 15 down to 14

	localparam opcode_t OPC_BSR  = 6'h34;       // Branch to subroutine
	localparam opcode_t OPC_JUMP = 6'h1a;       // JMP, JSR, RET, JSR_COROUTINE

	localparam jgrp_t JGRP_JSR       = 2'b01;
	localparam jgrp_t JGRP_RET       = 2'b10;
	localparam jgrp_t JGRP_COROUTINE = 2'b11;   // Not a call nor a return here

	function automatic opcode_t opcode_of(inst_t ir);
		return ir[31:26];
	endfunction

	function automatic jgrp_t jgrp_of(inst_t ir);
		return ir[15:14];
	endfunction

endpackage

// ==== hdl/bp_ifaces.sv ====
// Interfaces between the predictor blocks
// resolve_if carries one result bus slot to the training tables,
// ras_if links the call and return decode to the return address stack
interface resolve_if;
	logic          res_valid;    // Slot holds a finished instruction
	logic          res_cond;     // Conditional branch
	logic          res_uncond;   // Unconditional branch or jump
	logic          res_taken;    // Resolved direction
	bp_pkg::addr_t res_npc;      // Next PC of the resolved instruction
	bp_pkg::addr_t res_target;   // Computed branch target

	// Tables only read the slot, no handshake back
	modport sink (
		input res_valid, res_cond, res_uncond, res_taken, res_npc, res_target
	);
endinterface

interface ras_if;
	logic          push;         // Call seen at fetch
	bp_pkg::addr_t push_addr;    // Return address to save
	logic          pop;          // Return consumes the top entry
	bp_pkg::addr_t top_addr;     // Most recent return address
	logic          nonempty;     // At least one entry held

	modport ctrl (
		output push, push_addr, pop,
		input  top_addr, nonempty
	);
	modport stack (
		input  push, push_addr, pop,
		output top_addr, nonempty
	);
endinterface

// ==== hdl/branch_target_buffer.sv ====
// Direct-mapped BTB, looked up with the fetch PC and trained from the result bus
// Hit means the indexed entry is valid and its tag matches
module branch_target_buffer #(
	parameter int BTB_IDX_W = 5
) (
	input  logic          clock,
	input  logic          reset,
	input  bp_pkg::addr_t fetch_npc,
	resolve_if.sink       resolve,
	output logic          btb_hit,
	output bp_pkg::addr_t btb_target
);

	localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
	localparam int TAG_LSB     = BTB_IDX_W + 2;   // Above index and byte offset

	typedef logic [BTB_IDX_W-1:0]  btb_idx_t;
	typedef logic [63:TAG_LSB]     btb_tag_t;

	btb_tag_t         tag_mem    [BTB_ENTRIES];
	bp_pkg::addr_t    target_mem [BTB_ENTRIES];
	logic [BTB_ENTRIES-1:0] valid_bits;

	bp_pkg::addr_t fetch_pc;
	bp_pkg::addr_t res_pc;
	btb_idx_t      fetch_idx;
	btb_idx_t      res_idx;
	btb_tag_t      fetch_tag;
	btb_tag_t      res_tag;
	logic          train;

	assign fetch_pc  = bp_pkg::pc_of(fetch_npc);
	assign fetch_idx = fetch_pc[TAG_LSB-1:2];
	assign fetch_tag = fetch_pc[63:TAG_LSB];

	assign res_pc  = bp_pkg::pc_of(resolve.res_npc);
	assign res_idx = res_pc[TAG_LSB-1:2];
	assign res_tag = res_pc[63:TAG_LSB];
	assign train   = resolve.res_valid && (resolve.res_cond || resolve.res_uncond);

	// Lookup reads the old entry even when the same index is trained this cycle
	assign btb_hit    = valid_bits[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);
	assign btb_target = target_mem[fetch_idx];

	always_ff @(posedge clock) begin
		if (train) begin
			tag_mem[res_idx]    <= res_tag;            // Last writer owns the set
			target_mem[res_idx] <= resolve.res_target;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;                          // All entries miss after reset
		end else if (train) begin
			valid_bits[res_idx] <= 1'b1;
		end
	end

endmodule

// ==== hdl/local_history_predictor.sv ====
// Local history direction predictor
// Per-PC histories in the BHT select a 2-bit counter in the PHT,
// the counter's upper bit is the taken prediction
// Trained by conditional branches on the result bus
module local_history_predictor #(
	parameter int BHT_IDX_W = 5,
	parameter int HIST_W    = 4
) (
	input  logic          clock,
	input  logic          reset,
	input  bp_pkg::addr_t fetch_npc,
	resolve_if.sink       resolve,
	output logic          hist_taken
);

	localparam int BHT_ENTRIES = 1 << BHT_IDX_W;
	localparam int PHT_ENTRIES = 1 << HIST_W;      // History is the PHT index

	typedef logic [BHT_IDX_W-1:0] bht_idx_t;
	typedef logic [HIST_W-1:0]    hist_t;

	hist_t            bht_mem [BHT_ENTRIES];
	bp_pkg::pht_ctr_t pht_mem [PHT_ENTRIES];

	bp_pkg::addr_t    fetch_pc;
	bp_pkg::addr_t    res_pc;
	bht_idx_t         fetch_idx;
	bht_idx_t         res_idx;
	hist_t            fetch_hist;
	hist_t            res_hist;                    // History before this outcome
	logic [HIST_W:0]  res_hist_wide;               // Old history with outcome appended
	bp_pkg::pht_ctr_t res_ctr;
	bp_pkg::pht_ctr_t res_ctr_next;
	logic             train;

	assign fetch_pc   = bp_pkg::pc_of(fetch_npc);
	assign fetch_idx  = fetch_pc[BHT_IDX_W+1:2];
	assign fetch_hist = bht_mem[fetch_idx];
	assign hist_taken = pht_mem[fetch_hist][1];    // Upper counter bit

	assign res_pc        = bp_pkg::pc_of(resolve.res_npc);
	assign res_idx       = res_pc[BHT_IDX_W+1:2];
	assign res_hist      = bht_mem[res_idx];
	assign res_hist_wide = {res_hist, resolve.res_taken};  // Oldest bit drops off the top
	assign res_ctr       = pht_mem[res_hist];
	assign train         = resolve.res_valid && resolve.res_cond;

	// Saturating step toward the resolved direction
	always_comb begin
		res_ctr_next = res_ctr;
		if (resolve.res_taken && res_ctr != bp_pkg::PHT_STRONG_T) begin
			res_ctr_next = res_ctr + 2'd1;
		end else if (!resolve.res_taken && res_ctr != bp_pkg::PHT_STRONG_NT) begin
			res_ctr_next = res_ctr - 2'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				bht_mem[i] <= '0;
			end
			for (int i = 0; i < PHT_ENTRIES; i++) begin
				pht_mem[i] <= bp_pkg::pht_reset_value(i);  // All-ones histories lean taken
			end
		end else if (train) begin
			bht_mem[res_idx]  <= res_hist_wide[HIST_W-1:0];
			pht_mem[res_hist] <= res_ctr_next;
		end
	end

endmodule

// ==== hdl/return_address_stack.sv ====
// Circular return address stack
// Calls push, returns pop, a full stack overwrites its oldest entry
// A mispredict empties the stack ahead of any push or pop
module return_address_stack #(
	parameter int RAS_DEPTH = 8
) (
	input  logic   clock,
	input  logic   reset,
	input  logic   mispredict,
	ras_if.stack   ras
);

	localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
	localparam int CNT_W = $clog2(RAS_DEPTH + 1);      // Holds 0 up to RAS_DEPTH

	typedef logic [PTR_W-1:0] ras_ptr_t;
	typedef logic [CNT_W-1:0] ras_cnt_t;

	bp_pkg::addr_t stack_mem [RAS_DEPTH];

	ras_ptr_t wr_ptr;                                  // Next free slot
	ras_ptr_t ptr_inc;
	ras_ptr_t ptr_dec;                                 // Slot of the top entry
	ras_cnt_t count;
	logic     is_full;

	// Pointer wraps at RAS_DEPTH, also for depths that are not a power of two
	assign ptr_inc = (wr_ptr == ras_ptr_t'(RAS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
	assign ptr_dec = (wr_ptr == '0) ? ras_ptr_t'(RAS_DEPTH - 1) : wr_ptr - 1'b1;
	assign is_full = (count == ras_cnt_t'(RAS_DEPTH));

	assign ras.top_addr = stack_mem[ptr_dec];
	assign ras.nonempty = (count != '0);

	always_ff @(posedge clock) begin
		if (ras.push && !mispredict) begin
			stack_mem[wr_ptr] <= ras.push_addr;        // Oldest entry lost when full
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			count  <= '0;
		end else if (mispredict) begin
			wr_ptr <= '0;                              // Wrong path calls are discarded
			count  <= '0;
		end else if (ras.push) begin
			wr_ptr <= ptr_inc;
			if (!is_full) begin
				count <= count + 1'b1;                 // Saturates at RAS_DEPTH
			end
		end else if (ras.pop && ras.nonempty) begin
			wr_ptr <= ptr_dec;
			count  <= count - 1'b1;
		end
	end

endmodule

// ==== hdl/predict_select.sv ====
// Call and return decode for the fetch slot, plus the final prediction
// A return with a live stack entry beats the BTB, otherwise a BTB hit
// predicts taken for calls or when the local history says so
module predict_select (
	input  logic                 fetch_valid,
	input  bp_pkg::addr_t        fetch_npc,
	input  alpha_isa_pkg::inst_t fetch_ir,
	input  logic                 btb_hit,
	input  bp_pkg::addr_t        btb_target,
	input  logic                 hist_taken,
	ras_if.ctrl                  ras,
	output bp_pkg::addr_t        pred_target,
	output logic                 pred_taken
);

	alpha_isa_pkg::opcode_t opcode;
	alpha_isa_pkg::jgrp_t   jgrp;
	logic                   is_call;
	logic                   is_ret;
	logic                   use_ras;

	assign opcode = alpha_isa_pkg::opcode_of(fetch_ir);
	assign jgrp   = alpha_isa_pkg::jgrp_of(fetch_ir);

	always_comb begin
		is_call = (opcode == alpha_isa_pkg::OPC_BSR);  // BSR is always a call
		is_ret  = 1'b0;
		if (opcode == alpha_isa_pkg::OPC_JUMP) begin
			case (jgrp)
				alpha_isa_pkg::JGRP_JSR:       is_call = 1'b1;
				alpha_isa_pkg::JGRP_RET:       is_ret  = 1'b1;
				alpha_isa_pkg::JGRP_COROUTINE: is_call = 1'b0;  // Left to the BTB
				default:                       is_call = 1'b0;  // Plain JMP
			endcase
		end
	end

	assign use_ras = fetch_valid && is_ret && ras.nonempty;

	assign ras.push      = fetch_valid && is_call;
	assign ras.push_addr = fetch_npc;                  // Return lands after the call
	assign ras.pop       = use_ras;

	always_comb begin
		if (use_ras) begin
			pred_target = ras.top_addr;
			pred_taken  = 1'b1;
		end else if (fetch_valid && btb_hit) begin
			pred_target = btb_target;
			pred_taken  = is_call || hist_taken;       // Calls always redirect
		end else begin
			pred_target = '0;
			pred_taken  = 1'b0;
		end
	end

endmodule

// ==== hdl/branch_predictor.sv ====
// Top level of the single-slot fetch-stage branch predictor
// Fetch inputs get a zero-latency target and direction, the result bus
// trains BTB and local history tables, mispredict clears the RAS
module branch_predictor #(
	parameter int BTB_IDX_W = 5,
	parameter int BHT_IDX_W = 5,
	parameter int HIST_W    = 4,
	parameter int RAS_DEPTH = 8
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 fetch_valid,
	input  bp_pkg::addr_t        fetch_npc,
	input  alpha_isa_pkg::inst_t fetch_ir,
	input  logic                 res_valid,
	input  logic                 res_cond,
	input  logic                 res_uncond,
	input  logic                 res_taken,
	input  bp_pkg::addr_t        res_npc,
	input  bp_pkg::addr_t        res_target,
	input  logic                 mispredict,
	output bp_pkg::addr_t        pred_target,
	output logic                 pred_taken
);

	logic          btb_hit;
	bp_pkg::addr_t btb_target;
	logic          hist_taken;

	resolve_if resolve ();
	ras_if     ras ();

	assign resolve.res_valid  = res_valid;         // Result slot fans out to both tables
	assign resolve.res_cond   = res_cond;
	assign resolve.res_uncond = res_uncond;
	assign resolve.res_taken  = res_taken;
	assign resolve.res_npc    = res_npc;
	assign resolve.res_target = res_target;

	branch_target_buffer #(.BTB_IDX_W(BTB_IDX_W)) btb_i (
		.clock, .reset, .fetch_npc, .resolve(resolve.sink), .btb_hit, .btb_target
	);

	local_history_predictor #(.BHT_IDX_W(BHT_IDX_W), .HIST_W(HIST_W)) lhp_i (
		.clock, .reset, .fetch_npc, .resolve(resolve.sink), .hist_taken
	);

	return_address_stack #(.RAS_DEPTH(RAS_DEPTH)) ras_i (
		.clock, .reset, .mispredict, .ras(ras.stack)
	);

	predict_select select_i (
		.fetch_valid, .fetch_npc, .fetch_ir, .btb_hit, .btb_target, .hist_taken,
		.ras(ras.ctrl), .pred_target, .pred_taken
	);

endmodule

// ==== sim/bp_model.svh ====
// Reference model of the BTB, the local history tables and the return stack
// Included inside the testbench module, reads the DUT inputs that the testbench drives
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

bp_pkg::addr_t     m_btb_pc  [1 << BTB_IDX_W];     // PC that last trained each set
bp_pkg::addr_t     m_btb_tgt [1 << BTB_IDX_W];
logic              m_btb_vld [1 << BTB_IDX_W];
logic [HIST_W-1:0] m_bht     [1 << BHT_IDX_W];
logic [1:0]        m_pht     [1 << HIST_W];
bp_pkg::addr_t     m_ras     [$];                   // Back is the top, oldest dropped first

function automatic logic decodes_call(alpha_isa_pkg::inst_t ir);
	return ir[31:26] == alpha_isa_pkg::OPC_BSR ||
		(ir[31:26] == alpha_isa_pkg::OPC_JUMP && ir[15:14] == alpha_isa_pkg::JGRP_JSR);
endfunction

function automatic logic decodes_ret(alpha_isa_pkg::inst_t ir);
	return ir[31:26] == alpha_isa_pkg::OPC_JUMP && ir[15:14] == alpha_isa_pkg::JGRP_RET;
endfunction

task automatic model_reset();
	for (int i = 0; i < (1 << BTB_IDX_W); i++)
		m_btb_vld[i] = 1'b0;
	for (int i = 0; i < (1 << BHT_IDX_W); i++)
		m_bht[i] = '0;
	for (int i = 0; i < (1 << HIST_W); i++)
		m_pht[i] = bp_pkg::PHT_WEAK_NT;
	for (int k = 1; k <= HIST_W; k++)
		m_pht[(1 << k) - 1] = bp_pkg::PHT_WEAK_T;     // Histories 1, 3, 7 and so on
	m_ras.delete();
endtask

// Prediction for the inputs now on the DUT, from the state before the next edge
task automatic model_predict(output logic taken, output bp_pkg::addr_t target);
	bp_pkg::addr_t        pc;
	logic [BTB_IDX_W-1:0] bi;
	logic [BHT_IDX_W-1:0] hi;
	pc     = fetch_npc - bp_pkg::INST_BYTES;
	bi     = pc[BTB_IDX_W+1:2];
	hi     = pc[BHT_IDX_W+1:2];
	taken  = 1'b0;
	target = '0;
	if (fetch_valid && decodes_ret(fetch_ir) && m_ras.size() > 0) begin
		taken  = 1'b1;
		target = m_ras[$];
	end else if (fetch_valid && m_btb_vld[bi] && m_btb_pc[bi][63:2] == pc[63:2]) begin
		target = m_btb_tgt[bi];
		taken  = decodes_call(fetch_ir) || m_pht[m_bht[hi]][1];  // Counter upper bit
	end
endtask

// State change that the coming rising edge makes
task automatic model_step();
	bp_pkg::addr_t        pc;
	logic [BTB_IDX_W-1:0] bi;
	logic [BHT_IDX_W-1:0] hi;
	logic [HIST_W-1:0]    h;
	pc = res_npc - bp_pkg::INST_BYTES;
	bi = pc[BTB_IDX_W+1:2];
	hi = pc[BHT_IDX_W+1:2];
	h  = m_bht[hi];
	if (res_valid && (res_cond || res_uncond)) begin
		m_btb_vld[bi] = 1'b1;
		m_btb_pc[bi]  = pc;
		m_btb_tgt[bi] = res_target;
	end
	if (res_valid && res_cond) begin
		if (res_taken && m_pht[h] != 2'd3)
			m_pht[h] = m_pht[h] + 2'd1;
		else if (!res_taken && m_pht[h] != 2'd0)
			m_pht[h] = m_pht[h] - 2'd1;
		m_bht[hi] = (h << 1) | HIST_W'(res_taken);  // Newest outcome at bit 0
	end
	if (mispredict) begin
		m_ras.delete();
	end else if (fetch_valid && decodes_call(fetch_ir)) begin
		m_ras.push_back(fetch_npc);
		if (m_ras.size() > RAS_DEPTH)
			void'(m_ras.pop_front());                  // Full stack loses its oldest
	end else if (fetch_valid && decodes_ret(fetch_ir) && m_ras.size() > 0) begin
		void'(m_ras.pop_back());
	end
endtask

`endif

// ==== sim/tb_branch_predictor.sv ====
// Testbench for the fetch-stage branch predictor
// Directed and seeded random fetches, results and mispredicts,
// every cycle checked against the model in bp_model.svh
module tb_branch_predictor;

	localparam int BTB_IDX_W = 5;
	localparam int BHT_IDX_W = 5;
	localparam int HIST_W    = 4;
	localparam int RAS_DEPTH = 8;
	localparam int SEED      = 32'h462ce265;

	localparam alpha_isa_pkg::opcode_t OPC_BNE = 6'h3d;  // Plain conditional branch

	localparam int IDLE_CYCLES  = 20;
	localparam int BTB_ROUNDS   = 4;                    // Three cycles per round
	localparam int HIST_CYCLES  = 30;
	localparam int RAS_CYCLES   = 2 * RAS_DEPTH + 6;
	localparam int CLEAR_CYCLES = 6;
	localparam int MIX_CYCLES   = 400;
	localparam int CYCLE_LIMIT  = 3 + IDLE_CYCLES + 3 * BTB_ROUNDS + HIST_CYCLES
		+ RAS_CYCLES + CLEAR_CYCLES + MIX_CYCLES + 50;  // Margin for idle edges

	logic                 clock;
	logic                 reset;
	logic                 fetch_valid;
	bp_pkg::addr_t        fetch_npc;
	alpha_isa_pkg::inst_t fetch_ir;
	logic                 res_valid;
	logic                 res_cond;
	logic                 res_uncond;
	logic                 res_taken;
	bp_pkg::addr_t        res_npc;
	bp_pkg::addr_t        res_target;
	logic                 mispredict;
	bp_pkg::addr_t        pred_target;
	logic                 pred_taken;

	int    cycle_count = 0;
	int    check_count = 0;
	int    error_count = 0;
	int    test_count  = 0;
	int    test_checks = 0;   // Counts at the start of the running test
	int    test_errors = 0;
	string test_name   = "reset";

	`include "bp_model.svh"

	branch_predictor #(
		.BTB_IDX_W(BTB_IDX_W), .BHT_IDX_W(BHT_IDX_W), .HIST_W(HIST_W), .RAS_DEPTH(RAS_DEPTH)
	) branch_predictor_i (
		.clock, .reset, .fetch_valid, .fetch_npc, .fetch_ir, .res_valid, .res_cond,
		.res_uncond, .res_taken, .res_npc, .res_target, .mispredict, .pred_target, .pred_taken
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	task automatic compare(string what, logic [63:0] expected, logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic idle_inputs();
		fetch_valid <= 1'b0;
		fetch_npc   <= '0;
		fetch_ir    <= '0;
		res_valid   <= 1'b0;
		res_cond    <= 1'b0;
		res_uncond  <= 1'b0;
		res_taken   <= 1'b0;
		res_npc     <= '0;
		res_target  <= '0;
		mispredict  <= 1'b0;
	endtask

	// Idle at the rising edge, drive tasks called after this override
	task automatic cycle_start();
		@(posedge clock);
		idle_inputs();
	endtask

	// Outputs are settled at the falling edge, then the model takes the next edge
	task automatic cycle_end();
		logic          exp_taken;
		bp_pkg::addr_t exp_target;
		@(negedge clock);
		model_predict(exp_taken, exp_target);
		compare("pred_taken", 64'(exp_taken), 64'(pred_taken));
		compare("pred_target", exp_target, pred_target);
		model_step();
	endtask

	task automatic drive_fetch(bp_pkg::addr_t npc, alpha_isa_pkg::inst_t ir);
		fetch_valid <= 1'b1;
		fetch_npc   <= npc;
		fetch_ir    <= ir;
	endtask

	task automatic drive_result(logic cond, logic uncond, logic taken,
		bp_pkg::addr_t npc, bp_pkg::addr_t target);
		res_valid  <= 1'b1;
		res_cond   <= cond;
		res_uncond <= uncond;
		res_taken  <= taken;
		res_npc    <= npc;
		res_target <= target;
	endtask

	// Three tags times eight sets so that lookups collide often
	function automatic bp_pkg::addr_t pool_npc();
		bp_pkg::addr_t pc;
		pc = 64'h0000_0abc_0000_0000;
		pc = pc | (bp_pkg::addr_t'($urandom_range(0, 2)) << (BTB_IDX_W + 2));
		pc = pc | (bp_pkg::addr_t'($urandom_range(0, 7)) << 2);
		return pc + bp_pkg::INST_BYTES;
	endfunction

	function automatic bp_pkg::addr_t rand_target();
		return {$urandom, $urandom} & ~64'd3;   // Word aligned
	endfunction

	function automatic alpha_isa_pkg::inst_t make_ir(alpha_isa_pkg::opcode_t opc,
		alpha_isa_pkg::jgrp_t grp);
		alpha_isa_pkg::inst_t ir;
		ir        = $urandom;                   // Random displacement and registers
		ir[31:26] = opc;
		ir[15:14] = grp;
		return ir;
	endfunction

	function automatic alpha_isa_pkg::jgrp_t rand_grp();
		return alpha_isa_pkg::jgrp_t'($urandom_range(0, 3));
	endfunction

	function automatic alpha_isa_pkg::inst_t random_ir();
		alpha_isa_pkg::opcode_t opc;
		case ($urandom_range(0, 3))
			0: opc = alpha_isa_pkg::OPC_BSR;
			1, 2: opc = alpha_isa_pkg::OPC_JUMP;  // JSR, RET, coroutine or JMP
			default: opc = OPC_BNE;
		endcase
		return make_ir(opc, rand_grp());
	endfunction

	task automatic begin_test(string name);
		test_name   = name;
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic end_test();
		test_count++;
		$display("test %s done: %0d checks, %0d errors", test_name,
			check_count - test_checks, error_count - test_errors);
	endtask

	initial begin
		bp_pkg::addr_t npc;
		bp_pkg::addr_t target;
		void'($urandom(SEED));
		reset <= 1'b1;
		idle_inputs();
		model_reset();
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		begin_test("idle_after_reset");                // No training, no calls
		repeat (IDLE_CYCLES) begin
			cycle_start();
			drive_fetch(pool_npc(), make_ir(OPC_BNE, rand_grp()));
			fetch_valid <= $urandom_range(0, 1) != 0;
			cycle_end();
		end
		end_test();

		begin_test("btb_train_hit_miss");
		repeat (BTB_ROUNDS) begin
			npc    = pool_npc();
			target = rand_target();
			cycle_start();
			drive_result(1'b0, 1'b1, 1'b1, npc, target);
			cycle_end();
			cycle_start();
			drive_fetch(npc, make_ir(alpha_isa_pkg::OPC_BSR, rand_grp()));
			cycle_end();
			cycle_start();                             // Same set, tag bit 40 differs
			drive_fetch(npc ^ (64'd1 << 40), make_ir(OPC_BNE, rand_grp()));
			cycle_end();
		end
		end_test();

		begin_test("local_history");
		npc    = pool_npc();
		target = rand_target();
		for (int i = 0; i < HIST_CYCLES; i++) begin
			cycle_start();
			drive_fetch(npc, make_ir(OPC_BNE, rand_grp()));
			// Taken run, not-taken run, then random outcomes
			drive_result(1'b1, 1'b0, (i < 8) || (i >= 16 && $urandom_range(0, 1) != 0),
				npc, target);
			cycle_end();
		end
		end_test();

		begin_test("return_stack");
		cycle_start();
		mispredict <= 1'b1;                           // Start from an empty stack
		cycle_end();
		for (int i = 0; i < RAS_DEPTH + 3; i++) begin
			cycle_start();
			npc = 64'h0000_0777_0000_1000 + (bp_pkg::addr_t'(i) << 3);
			if (i % 2 == 0)
				drive_fetch(npc, make_ir(alpha_isa_pkg::OPC_BSR, rand_grp()));
			else
				drive_fetch(npc, make_ir(alpha_isa_pkg::OPC_JUMP, alpha_isa_pkg::JGRP_JSR));
			cycle_end();
		end
		repeat (RAS_DEPTH + 2) begin                  // Last two find the stack empty
			cycle_start();
			drive_fetch(pool_npc(), make_ir(alpha_isa_pkg::OPC_JUMP, alpha_isa_pkg::JGRP_RET));
			cycle_end();
		end
		end_test();

		begin_test("mispredict_clear");
		npc = pool_npc();
		cycle_start();
		drive_result(1'b0, 1'b1, 1'b1, npc, rand_target());  // Fallback target for the return
		cycle_end();
		repeat (3) begin
			cycle_start();
			drive_fetch(pool_npc(), make_ir(alpha_isa_pkg::OPC_BSR, rand_grp()));
			cycle_end();
		end
		cycle_start();
		mispredict <= 1'b1;
		cycle_end();
		cycle_start();
		drive_fetch(npc, make_ir(alpha_isa_pkg::OPC_JUMP, alpha_isa_pkg::JGRP_RET));
		cycle_end();
		end_test();

		begin_test("random_mix");
		repeat (MIX_CYCLES) begin
			cycle_start();
			drive_fetch(pool_npc(), random_ir());
			fetch_valid <= $urandom_range(0, 3) != 0;
			drive_result($urandom_range(0, 1) != 0, $urandom_range(0, 1) != 0,
				$urandom_range(0, 1) != 0, pool_npc(), rand_target());
			res_valid  <= $urandom_range(0, 1) != 0;
			mispredict <= $urandom_range(0, 15) == 0;
			cycle_end();
		end
		end_test();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+sim
hdl/bp_pkg.sv
hdl/alpha_isa_pkg.sv
hdl/bp_ifaces.sv
hdl/branch_target_buffer.sv
hdl/local_history_predictor.sv
hdl/return_address_stack.sv
hdl/predict_select.sv
hdl/branch_predictor.sv
sim/tb_branch_predictor.sv

// ==== Makefile ====
# Verilator build and run of the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
RTL_TOP   ?= branch_predictor
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST)) sim/bp_model.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
